/* source/l2_pkg.sv */
// Cache geometry constants, address field types, burst type and controller state enums
`default_nettype none

package l2_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int LEN_W  = 8;

	// Geometry, 4 ways by 32 sets of 128-byte lines
	localparam int WAYS           = 4;
	localparam int SETS           = 32;
	localparam int LINE_BYTES     = 128;
	localparam int BEAT_BYTES     = DATA_W / 8;
	localparam int BEATS_PER_LINE = LINE_BYTES / BEAT_BYTES;

	// Address split into tag, index and offset
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int INDEX_W  = $clog2(SETS);
	localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;
	localparam int BEAT_W   = $clog2(BEATS_PER_LINE);
	localparam int WAY_W    = $clog2(WAYS);

	// A fill is always one whole line
	localparam int FILL_LEN = BEATS_PER_LINE - 1;

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [LEN_W-1:0]   len_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [BEAT_W-1:0]  beat_t;
	typedef logic [WAY_W-1:0]   way_t;

	// AXI burst encoding, WRAP not supported
	typedef enum logic [1:0] {
		BURST_FIXED = 2'd0,
		BURST_INCR  = 2'd1
	} burst_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FILL,
		ST_RESP_I,
		ST_RESP_D,
		ST_FENCE
	} l2_state_e;

endpackage

`default_nettype wire

/* source/l2_read_port.sv */
// First-level read burst engine with request capture, beat stepping and R channel
`timescale 1ns/1ps
`default_nettype none

module l2_read_port (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,
	input  wire  l2_pkg::addr_t    araddr,
	input  wire  l2_pkg::len_t     arlen,
	input  wire  l2_pkg::burst_e   arburst,
	output logic                   arready,
	output logic                   rd_req,
	output l2_pkg::beat_t          rd_beat,
	input  wire  l2_pkg::data_t    rdata_in,
	output l2_pkg::data_t          rdata,
	output logic                   rlast,
	output logic                   rvalid,
	input  wire                    rready,
	output logic                   done
);
	import l2_pkg::*;

	// Captured request
	addr_t  addr_q;
	len_t   len_q;
	burst_e burst_q;
	len_t   cnt_q;

	// Burst control
	logic active_q;
	logic pend_q;
	logic rvalid_q;
	logic beat_xfer;

	assign arready   = start;
	assign beat_xfer = rvalid_q & rready;

	// Next read only after the beat in flight has gone
	assign rd_req  = active_q & ~pend_q & ~rvalid_q;
	assign rd_beat = addr_q[OFFSET_W-1 -: BEAT_W];

	// Data store holds its output, so rdata stays put under back-pressure
	assign rdata  = rdata_in;
	assign rvalid = rvalid_q;
	assign rlast  = rvalid_q & (cnt_q == len_q);
	assign done   = beat_xfer & rlast;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			pend_q   <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (start) begin
				active_q <= 1'b1;
			end else if (done) begin
				active_q <= 1'b0;
			end
			pend_q <= rd_req;
			// Valid one cycle after the synchronous read
			if (pend_q) begin
				rvalid_q <= 1'b1;
			end else if (beat_xfer) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= araddr;
			len_q   <= arlen;
			burst_q <= arburst;
			cnt_q   <= '0;
		end else if (beat_xfer) begin
			cnt_q <= cnt_q + 1'b1;
			// FIXED bursts keep re-reading the same beat
			if (burst_q == BURST_INCR) begin
				addr_q <= addr_q + addr_t'(BEAT_BYTES);
			end
		end
	end

endmodule

`default_nettype wire

/* source/l2_tag_store.sv */
// Tag and valid arrays with hit compare, LFSR victim choice and fence clear
`timescale 1ns/1ps
`default_nettype none

module l2_tag_store (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire  l2_pkg::addr_t    lookup_addr,
	input  wire                    alloc,
	input  wire  l2_pkg::way_t     alloc_way,
	input  wire                    fill_done,
	input  wire                    clear_all,
	output logic                   hit,
	output l2_pkg::way_t           hit_way,
	output l2_pkg::way_t           victim_way
);
	import l2_pkg::*;

	// Per set and way
	tag_t            tag_q [SETS][WAYS];
	logic [WAYS-1:0] valid_q [SETS];

	// Free-running replacement source
	logic [15:0] lfsr_q;

	index_t          index;
	tag_t            tag;
	logic [WAYS-1:0] set_valid;
	logic [WAYS-1:0] way_hit;

	assign index     = lookup_addr[OFFSET_W +: INDEX_W];
	assign tag       = lookup_addr[ADDR_W-1 -: TAG_W];
	assign set_valid = valid_q[index];

	always_comb begin
		way_hit = '0;
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = set_valid[w] & (tag_q[index][w] == tag);
		end
	end

	assign hit = |way_hit;

	// Scan downward so the lowest matching way wins
	always_comb begin
		hit_way    = '0;
		victim_way = lfsr_q[WAY_W-1:0];
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit_way = way_t'(w);
			end
			// Any invalid way beats the random pick
			if (!set_valid[w]) begin
				victim_way = way_t'(w);
			end
		end
	end

	// Taps 16 14 13 11, maximal length
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr_q <= 16'hace1;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (clear_all) begin
			// Fence drops every line at once
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (alloc) begin
			valid_q[index][alloc_way] <= 1'b0;
		end else if (fill_done) begin
			valid_q[index][alloc_way] <= 1'b1;
		end
	end

	// New tag written as the fill starts
	always_ff @(posedge clk) begin
		if (alloc) begin
			tag_q[index][alloc_way] <= tag;
		end
	end

endmodule

`default_nettype wire

/* source/l2_data_store.sv */
// Line data array with synchronous write, synchronous read and held read output
`timescale 1ns/1ps
`default_nettype none

module l2_data_store (
	input  wire                    clk,
	input  wire                    rd_en,
	input  wire                    wr_en,
	input  wire  l2_pkg::way_t     way,
	input  wire  l2_pkg::index_t   index,
	input  wire  l2_pkg::beat_t    beat,
	input  wire  l2_pkg::data_t    wdata,
	output l2_pkg::data_t          rdata
);
	import l2_pkg::*;

	// One beat per entry, addressed by way, set and beat
	data_t mem_q [WAYS][SETS][BEATS_PER_LINE];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_q[way][index][beat] <= wdata;
		end
	end

	// Output register keeps the last beat while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= mem_q[way][index][beat];
		end
	end

endmodule

`default_nettype wire

/* source/l2_ctrl.sv */
// Cache controller FSM with port arbitration, line fill, fence and data store multiplexing
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl (
	input  wire                    clk,
	input  wire                    rst_n,

	// Port requests
	input  wire  l2_pkg::addr_t    il1_araddr,
	input  wire                    il1_arvalid,
	input  wire  l2_pkg::addr_t    dl1_araddr,
	input  wire                    dl1_arvalid,
	input  wire                    fence,
	output logic                   fence_end,

	// Tag store
	input  wire                    hit,
	input  wire  l2_pkg::way_t     hit_way,
	input  wire  l2_pkg::way_t     victim_way,
	output l2_pkg::addr_t          lookup_addr,
	output logic                   alloc,
	output l2_pkg::way_t           alloc_way,
	output logic                   fill_done,
	output logic                   clear_all,

	// Read port engines
	output logic                   start_i,
	output logic                   start_d,
	input  wire                    i_rd_req,
	input  wire  l2_pkg::beat_t    i_rd_beat,
	input  wire                    d_rd_req,
	input  wire  l2_pkg::beat_t    d_rd_beat,
	input  wire                    done_i,
	input  wire                    done_d,

	// Data store
	output logic                   st_rd_en,
	output logic                   st_wr_en,
	output l2_pkg::way_t           st_way,
	output l2_pkg::index_t         st_index,
	output l2_pkg::beat_t          st_beat,
	output l2_pkg::data_t          st_wdata,

	// Memory read channels
	output l2_pkg::addr_t          mem_araddr,
	output l2_pkg::len_t           mem_arlen,
	output l2_pkg::burst_e         mem_arburst,
	output logic                   mem_arvalid,
	input  wire                    mem_arready,
	input  wire  l2_pkg::data_t    mem_rdata,
	input  wire                    mem_rvalid,
	input  wire                    mem_rlast,
	output logic                   mem_rready
);
	import l2_pkg::*;

	l2_state_e state_q;
	l2_state_e state_d;

	// Request under service
	addr_t req_addr_q;
	logic  gnt_d_q;
	way_t  way_q;

	// Fill progress
	beat_t fill_beat_q;
	logic  mem_arvalid_q;
	logic  mem_beat;
	logic  go_fill;

	assign mem_beat = mem_rvalid & mem_rready;
	assign go_fill  = (state_q == ST_LOOKUP) & ~hit;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				// Fence first, then il1, then dl1
				if (fence) begin
					state_d = ST_FENCE;
				end else if (il1_arvalid | dl1_arvalid) begin
					state_d = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (!hit) begin
					state_d = ST_FILL;
				end else if (gnt_d_q) begin
					state_d = ST_RESP_D;
				end else begin
					state_d = ST_RESP_I;
				end
			end
			// Line complete, look it up again so it hits
			ST_FILL:   state_d = (mem_beat & mem_rlast) ? ST_LOOKUP : ST_FILL;
			ST_RESP_I: state_d = done_i ? ST_IDLE : ST_RESP_I;
			ST_RESP_D: state_d = done_d ? ST_IDLE : ST_RESP_D;
			ST_FENCE:  state_d = ST_IDLE;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q       <= ST_IDLE;
			gnt_d_q       <= 1'b0;
			mem_arvalid_q <= 1'b0;
			fill_beat_q   <= '0;
		end else begin
			state_q <= state_d;
			// Grant goes to dl1 only when il1 is idle
			if ((state_q == ST_IDLE) && (state_d == ST_LOOKUP)) begin
				gnt_d_q <= ~il1_arvalid;
			end
			// AR raised once per fill, dropped on acceptance
			if (go_fill) begin
				mem_arvalid_q <= 1'b1;
			end else if (mem_arready) begin
				mem_arvalid_q <= 1'b0;
			end
			if (go_fill) begin
				fill_beat_q <= '0;
			end else if (mem_beat) begin
				fill_beat_q <= fill_beat_q + 1'b1;
			end
		end
	end

	// Lock address and way for the rest of the transaction
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE) begin
			req_addr_q <= il1_arvalid ? il1_araddr : dl1_araddr;
		end
		if (state_q == ST_LOOKUP) begin
			way_q <= hit ? hit_way : victim_way;
		end
	end

	// Tag store control
	assign lookup_addr = req_addr_q;
	assign alloc       = go_fill;
	assign alloc_way   = (state_q == ST_LOOKUP) ? victim_way : way_q;
	assign fill_done   = (state_q == ST_FILL) & mem_beat & mem_rlast;
	assign clear_all   = (state_q == ST_FENCE);
	assign fence_end   = (state_q == ST_FENCE);

	// Port start doubles as arready
	assign start_i = (state_q == ST_LOOKUP) & hit & ~gnt_d_q;
	assign start_d = (state_q == ST_LOOKUP) & hit & gnt_d_q;

	// Whole aligned line, one INCR burst
	assign mem_araddr  = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign mem_arlen   = len_t'(FILL_LEN);
	assign mem_arburst = BURST_INCR;
	assign mem_arvalid = mem_arvalid_q;
	assign mem_rready  = (state_q == ST_FILL);

	// Data store owner follows the state
	always_comb begin
		st_rd_en = 1'b0;
		st_wr_en = 1'b0;
		st_beat  = fill_beat_q;
		case (state_q)
			ST_FILL: begin
				st_wr_en = mem_beat;
			end
			ST_RESP_I: begin
				st_rd_en = i_rd_req;
				st_beat  = i_rd_beat;
			end
			ST_RESP_D: begin
				st_rd_en = d_rd_req;
				st_beat  = d_rd_beat;
			end
			default: begin
				st_rd_en = 1'b0;
			end
		endcase
	end

	// Bursts stay in one line, so the locked index serves the port too
	assign st_way   = way_q;
	assign st_index = req_addr_q[OFFSET_W +: INDEX_W];
	assign st_wdata = mem_rdata;

endmodule

`default_nettype wire

/* source/l2_cache_top.sv */
// Cache top level wiring the controller, both read ports, tag store and data store
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top (
	input  wire                    clk,
	input  wire                    rst_n,

	// Instruction side
	input  wire  l2_pkg::addr_t    il1_araddr,
	input  wire  l2_pkg::len_t     il1_arlen,
	input  wire  l2_pkg::burst_e   il1_arburst,
	input  wire                    il1_arvalid,
	output logic                   il1_arready,
	output l2_pkg::data_t          il1_rdata,
	output logic                   il1_rlast,
	output logic                   il1_rvalid,
	input  wire                    il1_rready,

	// Data side
	input  wire  l2_pkg::addr_t    dl1_araddr,
	input  wire  l2_pkg::len_t     dl1_arlen,
	input  wire  l2_pkg::burst_e   dl1_arburst,
	input  wire                    dl1_arvalid,
	output logic                   dl1_arready,
	output l2_pkg::data_t          dl1_rdata,
	output logic                   dl1_rlast,
	output logic                   dl1_rvalid,
	input  wire                    dl1_rready,

	// Memory side
	output l2_pkg::addr_t          mem_araddr,
	output l2_pkg::len_t           mem_arlen,
	output l2_pkg::burst_e         mem_arburst,
	output logic                   mem_arvalid,
	input  wire                    mem_arready,
	input  wire  l2_pkg::data_t    mem_rdata,
	input  wire                    mem_rlast,
	input  wire                    mem_rvalid,
	output logic                   mem_rready,

	input  wire                    fence,
	output logic                   fence_end
);
	import l2_pkg::*;

	// Controller to ports
	logic  start_i;
	logic  start_d;
	logic  i_rd_req;
	logic  d_rd_req;
	beat_t i_rd_beat;
	beat_t d_rd_beat;
	logic  done_i;
	logic  done_d;

	// Tag store handshake
	addr_t lookup_addr;
	logic  alloc;
	way_t  alloc_way;
	logic  fill_done;
	logic  clear_all;
	logic  hit;
	way_t  hit_way;
	way_t  victim_way;

	// Data store access, shared by fill and both ports
	logic   st_rd_en;
	logic   st_wr_en;
	way_t   st_way;
	index_t st_index;
	beat_t  st_beat;
	data_t  st_wdata;
	data_t  st_rdata;

	l2_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.il1_araddr  (il1_araddr),
		.il1_arvalid (il1_arvalid),
		.dl1_araddr  (dl1_araddr),
		.dl1_arvalid (dl1_arvalid),
		.fence       (fence),
		.fence_end   (fence_end),
		.hit         (hit),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.lookup_addr (lookup_addr),
		.alloc       (alloc),
		.alloc_way   (alloc_way),
		.fill_done   (fill_done),
		.clear_all   (clear_all),
		.start_i     (start_i),
		.start_d     (start_d),
		.i_rd_req    (i_rd_req),
		.i_rd_beat   (i_rd_beat),
		.d_rd_req    (d_rd_req),
		.d_rd_beat   (d_rd_beat),
		.done_i      (done_i),
		.done_d      (done_d),
		.st_rd_en    (st_rd_en),
		.st_wr_en    (st_wr_en),
		.st_way      (st_way),
		.st_index    (st_index),
		.st_beat     (st_beat),
		.st_wdata    (st_wdata),
		.mem_araddr  (mem_araddr),
		.mem_arlen   (mem_arlen),
		.mem_arburst (mem_arburst),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rvalid  (mem_rvalid),
		.mem_rlast   (mem_rlast),
		.mem_rready  (mem_rready)
	);

	// Instruction port engine
	l2_read_port u_port_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_i),
		.araddr   (il1_araddr),
		.arlen    (il1_arlen),
		.arburst  (il1_arburst),
		.arready  (il1_arready),
		.rd_req   (i_rd_req),
		.rd_beat  (i_rd_beat),
		.rdata_in (st_rdata),
		.rdata    (il1_rdata),
		.rlast    (il1_rlast),
		.rvalid   (il1_rvalid),
		.rready   (il1_rready),
		.done     (done_i)
	);

	// Data port engine
	l2_read_port u_port_d (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_d),
		.araddr   (dl1_araddr),
		.arlen    (dl1_arlen),
		.arburst  (dl1_arburst),
		.arready  (dl1_arready),
		.rd_req   (d_rd_req),
		.rd_beat  (d_rd_beat),
		.rdata_in (st_rdata),
		.rdata    (dl1_rdata),
		.rlast    (dl1_rlast),
		.rvalid   (dl1_rvalid),
		.rready   (dl1_rready),
		.done     (done_d)
	);

	l2_tag_store u_tag_store (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (lookup_addr),
		.alloc       (alloc),
		.alloc_way   (alloc_way),
		.fill_done   (fill_done),
		.clear_all   (clear_all),
		.hit         (hit),
		.hit_way     (hit_way),
		.victim_way  (victim_way)
	);

	l2_data_store u_data_store (
		.clk   (clk),
		.rd_en (st_rd_en),
		.wr_en (st_wr_en),
		.way   (st_way),
		.index (st_index),
		.beat  (st_beat),
		.wdata (st_wdata),
		.rdata (st_rdata)
	);

endmodule

`default_nettype wire

/* tb/l2_mem_model.sv */
// Memory-side AR/R responder with address pattern data, random delays and a fill counter
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire  l2_pkg::addr_t    araddr,
	input  wire  l2_pkg::len_t     arlen,
	input  wire  l2_pkg::burst_e   arburst,
	input  wire                    arvalid,
	output logic                   arready,
	output l2_pkg::data_t          rdata,
	output logic                   rlast,
	output logic                   rvalid,
	input  wire                    rready,
	output int                     fill_count,
	output logic                   stalled
);
	import l2_pkg::*;

	// Longest wait for rready on one beat
	localparam int MAX_WAIT = 1000;

	// Address in the upper half, its inverse in the lower half
	function automatic data_t beat_pattern(input addr_t a);
		return {a, ~a};
	endfunction

	initial begin
		addr_t  a;
		len_t   len;
		burst_e burst;
		int     wait_cnt;
		arready    = 1'b0;
		rdata      = '0;
		rlast      = 1'b0;
		rvalid     = 1'b0;
		fill_count = 0;
		stalled    = 1'b0;
		forever begin
			@(posedge clk);
			if (rst_n && arvalid) begin
				// Random accept delay, then a one-cycle arready
				repeat ($urandom_range(0, 3)) begin
					@(posedge clk);
				end
				arready <= 1'b1;
				@(posedge clk);
				arready    <= 1'b0;
				a          = araddr;
				len        = arlen;
				burst      = arburst;
				fill_count <= fill_count + 1;
				// First beat after a random gap
				repeat ($urandom_range(1, 4)) begin
					@(posedge clk);
				end
				for (int k = 0; k <= int'(len); k++) begin
					rvalid   <= 1'b1;
					rdata    <= beat_pattern(a);
					rlast    <= (k == int'(len));
					wait_cnt = 0;
					do begin
						@(posedge clk);
						wait_cnt++;
					end while (!rready && wait_cnt < MAX_WAIT);
					if (!rready) begin
						stalled <= 1'b1;
					end
					if (burst == BURST_INCR) begin
						a = a + addr_t'(BEAT_BYTES);
					end
				end
				rvalid <= 1'b0;
				rlast  <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* tb/tb_l2_cache.sv */
// Testbench for the L2 cache with clock, reset, port driver, compare tasks and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;
	import l2_pkg::*;

	// Cycle limit for every wait loop
	localparam int TIMEOUT = 2000;

	// Cycles watched for a stray beat after rlast
	localparam int TAIL_CYCLES = 4;

	logic   clk;
	logic   rst_n;

	// Instruction port
	addr_t  il1_araddr;
	len_t   il1_arlen;
	burst_e il1_arburst;
	logic   il1_arvalid;
	logic   il1_arready;
	data_t  il1_rdata;
	logic   il1_rlast;
	logic   il1_rvalid;
	logic   il1_rready;

	// Data port
	addr_t  dl1_araddr;
	len_t   dl1_arlen;
	burst_e dl1_arburst;
	logic   dl1_arvalid;
	logic   dl1_arready;
	data_t  dl1_rdata;
	logic   dl1_rlast;
	logic   dl1_rvalid;
	logic   dl1_rready;

	// Memory side
	addr_t  mem_araddr;
	len_t   mem_arlen;
	burst_e mem_arburst;
	logic   mem_arvalid;
	logic   mem_arready;
	data_t  mem_rdata;
	logic   mem_rlast;
	logic   mem_rvalid;
	logic   mem_rready;

	logic   fence;
	logic   fence_end;
	int     fill_count;
	logic   mem_stalled;

	int     errors;
	int     tests_run;
	int     tests_failed;

	l2_cache_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.il1_araddr  (il1_araddr),
		.il1_arlen   (il1_arlen),
		.il1_arburst (il1_arburst),
		.il1_arvalid (il1_arvalid),
		.il1_arready (il1_arready),
		.il1_rdata   (il1_rdata),
		.il1_rlast   (il1_rlast),
		.il1_rvalid  (il1_rvalid),
		.il1_rready  (il1_rready),
		.dl1_araddr  (dl1_araddr),
		.dl1_arlen   (dl1_arlen),
		.dl1_arburst (dl1_arburst),
		.dl1_arvalid (dl1_arvalid),
		.dl1_arready (dl1_arready),
		.dl1_rdata   (dl1_rdata),
		.dl1_rlast   (dl1_rlast),
		.dl1_rvalid  (dl1_rvalid),
		.dl1_rready  (dl1_rready),
		.mem_araddr  (mem_araddr),
		.mem_arlen   (mem_arlen),
		.mem_arburst (mem_arburst),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rlast   (mem_rlast),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.fence       (fence),
		.fence_end   (fence_end)
	);

	l2_mem_model u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.araddr     (mem_araddr),
		.arlen      (mem_arlen),
		.arburst    (mem_arburst),
		.arvalid    (mem_arvalid),
		.arready    (mem_arready),
		.rdata      (mem_rdata),
		.rlast      (mem_rlast),
		.rvalid     (mem_rvalid),
		.rready     (mem_rready),
		.fill_count (fill_count),
		.stalled    (mem_stalled)
	);

	always #20 clk = ~clk;

	// Memory model left a fill beat that mem_rready never took
	always @(posedge mem_stalled) begin
		$display("Memory model gave up waiting for mem_rready during a fill at %0t", $time);
		errors++;
	end

	// Beat at byte address a carries a and then ~a
	function automatic data_t expected_word(input addr_t a);
		return {a, ~a};
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_fills(input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t fill_count: got %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
		errors++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("Test %s: fail, %0d errors", name, errors - errs_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// One burst on either port, checking every beat against the address pattern
	task automatic read_burst(input logic use_d, input addr_t addr, input len_t len,
			input burst_e burst, input logic gaps, output time ar_time);
		string port;
		addr_t exp_addr;
		int    guard;
		int    count;
		logic  accepted;
		logic  ready_bit;
		logic  rv;
		logic  rr;
		logic  rl;
		data_t rd;
		port     = use_d ? "dl1" : "il1";
		exp_addr = addr;
		@(posedge clk);
		if (use_d) begin
			dl1_araddr  <= addr;
			dl1_arlen   <= len;
			dl1_arburst <= burst;
			dl1_arvalid <= 1'b1;
		end else begin
			il1_araddr  <= addr;
			il1_arlen   <= len;
			il1_arburst <= burst;
			il1_arvalid <= 1'b1;
		end
		guard    = 0;
		accepted = 1'b0;
		while (!accepted && guard < TIMEOUT) begin
			@(posedge clk);
			accepted = use_d ? dl1_arready : il1_arready;
			guard++;
		end
		ar_time = $time;
		if (use_d) begin
			dl1_arvalid <= 1'b0;
		end else begin
			il1_arvalid <= 1'b0;
		end
		if (!accepted) begin
			report_timeout({port, " arready"});
		end else begin
			count = 0;
			guard = 0;
			while (count <= int'(len) && guard < TIMEOUT) begin
				// Random gaps in rready under back-pressure
				ready_bit = gaps ? 1'($urandom_range(0, 1)) : 1'b1;
				if (use_d) begin
					dl1_rready <= ready_bit;
				end else begin
					il1_rready <= ready_bit;
				end
				@(posedge clk);
				guard++;
				rv = use_d ? dl1_rvalid : il1_rvalid;
				rr = use_d ? dl1_rready : il1_rready;
				rl = use_d ? dl1_rlast : il1_rlast;
				rd = use_d ? dl1_rdata : il1_rdata;
				if (rv && rr) begin
					check_data({port, "_rdata"}, rd, expected_word(exp_addr));
					check_flag({port, "_rlast"}, rl, logic'(count == int'(len)));
					count++;
					if (burst == BURST_INCR) begin
						exp_addr = exp_addr + addr_t'(BEAT_BYTES);
					end
				end
			end
			if (count <= int'(len)) begin
				report_timeout({port, " read data"});
			end else begin
				// Keep accepting, any beat past rlast is a duplicate
				if (use_d) begin
					dl1_rready <= 1'b1;
				end else begin
					il1_rready <= 1'b1;
				end
				for (int n = 0; n < TAIL_CYCLES; n++) begin
					@(posedge clk);
					rv = use_d ? dl1_rvalid : il1_rvalid;
					if (rv) begin
						count++;
					end
				end
				check_count({port, " beats"}, count, int'(len) + 1);
			end
			if (use_d) begin
				dl1_rready <= 1'b0;
			end else begin
				il1_rready <= 1'b0;
			end
		end
	endtask

	task automatic miss_then_hit();
		int  errs;
		int  fills;
		time t;
		errs  = errors;
		fills = fill_count;
		// Cold line, one fill
		read_burst(1'b0, 32'h0000_1000, len_t'(15), BURST_INCR, 1'b0, t);
		check_fills(fill_count, fills + 1);
		read_burst(1'b0, 32'h0000_1000, len_t'(15), BURST_INCR, 1'b0, t);
		check_fills(fill_count, fills + 1);
		report_test("miss then hit", errs);
	endtask

	task automatic port_arbitration();
		int  errs;
		int  fills;
		time t_i;
		time t_d;
		errs  = errors;
		fills = fill_count;
		// Both ports raise arvalid on the same edge
		fork
			read_burst(1'b0, 32'h0000_2080, len_t'(3), BURST_INCR, 1'b0, t_i);
			read_burst(1'b1, 32'h0000_3140, len_t'(7), BURST_INCR, 1'b0, t_d);
		join
		check_flag("il1 arready before dl1 arready", logic'(t_i < t_d), 1'b1);
		check_fills(fill_count, fills + 2);
		report_test("port arbitration", errs);
	endtask

	task automatic fixed_backpressure();
		int  errs;
		int  fills;
		time t;
		errs  = errors;
		fills = fill_count;
		read_burst(1'b1, 32'h0000_4198, len_t'(4), BURST_FIXED, 1'b1, t);
		check_fills(fill_count, fills + 1);
		report_test("fixed burst with back-pressure", errs);
	endtask

	task automatic fence_flush();
		int   errs;
		int   fills;
		int   guard;
		logic seen;
		time  t;
		errs  = errors;
		fills = fill_count;
		@(posedge clk);
		fence <= 1'b1;
		guard = 0;
		seen  = 1'b0;
		while (!seen && guard < TIMEOUT) begin
			@(posedge clk);
			seen = fence_end;
			guard++;
		end
		fence <= 1'b0;
		if (!seen) begin
			report_timeout("fence_end");
		end
		// Line from the first test is gone now
		read_burst(1'b0, 32'h0000_1000, len_t'(15), BURST_INCR, 1'b0, t);
		check_fills(fill_count, fills + 1);
		report_test("fence", errs);
	endtask

	task automatic set_eviction();
		int    errs;
		int    fills;
		addr_t a;
		time   t;
		errs  = errors;
		fills = fill_count;
		a     = '0;
		// Five tags in set 9, one more than the ways
		for (int n = 0; n < 5; n++) begin
			a = {tag_t'(n + 16), index_t'(9), {OFFSET_W{1'b0}}};
			read_burst(1'b1, a, len_t'(15), BURST_INCR, 1'b0, t);
		end
		check_fills(fill_count, fills + 5);
		read_burst(1'b1, a, len_t'(15), BURST_INCR, 1'b0, t);
		check_fills(fill_count, fills + 5);
		report_test("eviction", errs);
	endtask

	initial begin
		void'($urandom(32'h9471ff21));
		clk          = 1'b0;
		rst_n        = 1'b0;
		il1_araddr   = '0;
		il1_arlen    = '0;
		il1_arburst  = BURST_INCR;
		il1_arvalid  = 1'b0;
		il1_rready   = 1'b0;
		dl1_araddr   = '0;
		dl1_arlen    = '0;
		dl1_arburst  = BURST_INCR;
		dl1_arvalid  = 1'b0;
		dl1_rready   = 1'b0;
		fence        = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (10) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;
		@(posedge clk);
		miss_then_hit();
		port_arbitration();
		fixed_backpressure();
		fence_flush();
		set_eviction();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
source/l2_pkg.sv
source/l2_read_port.sv
source/l2_tag_store.sv
source/l2_data_store.sv
source/l2_ctrl.sv
source/l2_cache_top.sv
tb/l2_mem_model.sv
tb/tb_l2_cache.sv

/* Makefile */
# Verilator build, run and lint for the L2 cache

VERILATOR ?= verilator
TOP       ?= tb_l2_cache
RTL_TOP   ?= l2_cache_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
RTL_SRCS  ?= source/l2_pkg.sv source/l2_read_port.sv source/l2_tag_store.sv \
             source/l2_data_store.sv source/l2_ctrl.sv source/l2_cache_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
